/* common/cpu85_pkg.sv */
package cpu85_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0] reg_sel_t;

	// bus T-states, one per clk
	typedef enum logic [2:0] {
		TR, // reset
		T1,
		T2,
		TW, // wait on READY
		T3,
		T4,
		TT  // halt
	} tstate_e;

	// ----------------------------------------
	// machine cycle control and status
	// ----------------------------------------

	// {inta_, wr_, rd_, io/m_, s1, s0}
	typedef logic [5:0] cycle_code_t;

	localparam cycle_code_t CYCLE_OF  = 6'b110011; // opcode fetch
	localparam cycle_code_t CYCLE_MR  = 6'b110010; // memory read
	localparam cycle_code_t CYCLE_DR  = 6'b110110; // device read
	localparam cycle_code_t CYCLE_DW  = 6'b101101; // device write
	localparam cycle_code_t CYCLE_BIH = 6'b111100; // halt

	localparam int STAT_S0  = 0;
	localparam int STAT_S1  = 1;
	localparam int STAT_IOM = 2;
	localparam int CTRL_RD  = 3;
	localparam int CTRL_WR  = 4;

	// ----------------------------------------
	// opcode fields, 2-3-3 split
	// ----------------------------------------

	localparam logic [1:0] GRP_TXA = 2'b00; // transfer, immediate loads
	localparam logic [1:0] GRP_MOV = 2'b01; // register moves and hlt
	localparam logic [1:0] GRP_ALU = 2'b10; // alu on register
	localparam logic [1:0] GRP_SIC = 2'b11; // immediate alu, i/o

	localparam logic [2:0] LO_IMM  = 3'b110; // mvi / alu immediate
	localparam logic [2:0] LO_IO   = 3'b011;
	localparam logic [2:0] MID_OUT = 3'b010;
	localparam logic [2:0] MID_IN  = 3'b011;

	localparam reg_sel_t REG_M = 3'd6; // memory operand, not kept
	localparam reg_sel_t REG_A = 3'd7;

	localparam byte_t OPC_NOP  = 8'h00;
	localparam addr_t RESET_PC = 16'h0000;

	typedef enum logic [2:0] {
		CL_NOP,
		CL_MOV,
		CL_MVI,
		CL_ALU_R,
		CL_ALU_I,
		CL_IN,
		CL_OUT,
		CL_HLT
	} instr_class_e;

	// matches opcode bits 5:3
	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_SUB = 3'b010,
		ALU_ANA = 3'b100,
		ALU_XRA = 3'b101,
		ALU_ORA = 3'b110
	} alu_op_e;

endpackage

/* control/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
	input  cpu85_pkg::byte_t        i_ir,
	output cpu85_pkg::instr_class_e o_class,
	output logic [1:0]              o_extra_cycles,
	output logic                    o_device_cycle,
	output cpu85_pkg::alu_op_e      o_alu_op,
	output cpu85_pkg::reg_sel_t     o_dst,
	output cpu85_pkg::reg_sel_t     o_src
);
	import cpu85_pkg::*;

	logic [1:0] grp;
	reg_sel_t   mid;
	reg_sel_t   lo;
	logic       grp_txa, grp_mov, grp_alu, grp_sic;
	logic       mid_m, lo_m;
	logic       op_ok;

	assign grp = i_ir[7:6];
	assign mid = i_ir[5:3];
	assign lo  = i_ir[2:0];

	// top two bits pick the instruction group
	assign grp_txa = (grp == GRP_TXA);
	assign grp_mov = (grp == GRP_MOV);
	assign grp_alu = (grp == GRP_ALU);
	assign grp_sic = (grp == GRP_SIC);

	assign mid_m = (mid == REG_M);
	assign lo_m  = (lo == REG_M);

	// adc, sbb and cmp have no flags to work with
	always_comb begin
		case (mid)
			ALU_ADD, ALU_SUB, ALU_ANA, ALU_XRA, ALU_ORA: op_ok = 1'b1;
			default:                                     op_ok = 1'b0;
		endcase
	end

	always_comb begin
		o_class        = CL_NOP;
		o_extra_cycles = 2'd0;
		o_device_cycle = 1'b0;
		o_alu_op       = ALU_ADD;
		o_dst          = mid;
		o_src          = lo;
		if (grp_txa) begin
			if (lo == LO_IMM && !mid_m) begin // mvi r
				o_class        = CL_MVI;
				o_extra_cycles = 2'd1;
			end
		end else if (grp_mov) begin
			if (mid_m && lo_m)
				o_class = CL_HLT; // 76h
			else if (!mid_m && !lo_m)
				o_class = CL_MOV;
		end else if (grp_alu) begin
			if (op_ok && !lo_m) begin
				o_class  = CL_ALU_R;
				o_alu_op = alu_op_e'(mid);
				o_dst    = REG_A;
			end
		end else if (grp_sic) begin
			if (lo == LO_IMM && op_ok) begin
				o_class        = CL_ALU_I;
				o_extra_cycles = 2'd1;
				o_alu_op       = alu_op_e'(mid);
				o_dst          = REG_A;
			end else if (lo == LO_IO && (mid == MID_IN || mid == MID_OUT)) begin
				// port byte read, then the device cycle
				o_class        = (mid == MID_IN) ? CL_IN : CL_OUT;
				o_extra_cycles = 2'd2;
				o_device_cycle = 1'b1;
				o_dst          = REG_A;
			end
		end
	end

endmodule

/* control/cycle_sequencer.sv */
`timescale 1ns/1ns

module cycle_sequencer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_ready,
	input  cpu85_pkg::instr_class_e i_class,
	input  logic [1:0]              i_extra_cycles,
	input  logic                    i_device_cycle,
	output cpu85_pkg::tstate_e      o_state,
	output logic [1:0]              o_mcycle,
	output logic                    o_ale,
	output logic                    o_rd_n,
	output logic                    o_wr_n,
	output logic                    o_io_m_n,
	output logic                    o_s1,
	output logic                    o_s0,
	output logic                    o_ir_we,
	output logic                    o_temp_we,
	output logic                    o_reg_we,
	output logic                    o_pc_inc
);
	import cpu85_pkg::*;

	tstate_e     state, state_nx;
	logic [1:0]  mcycle, mcycle_nx; // 0 is the opcode fetch
	logic [1:0]  remain, remain_nx; // machine cycles left after fetch
	cycle_code_t code, code_nx;
	logic        bus_active;
	logic        last_mc;

	// ----------------------------------------
	// next state
	// ----------------------------------------

	always_comb begin
		state_nx  = state;
		mcycle_nx = mcycle;
		remain_nx = remain;
		case (state)
			TR: state_nx = T1;
			T1: state_nx = T2;
			T2, TW: state_nx = i_ready ? T3 : TW;
			T3: begin
				if (mcycle == 2'd0) begin
					state_nx = T4;
				end else begin
					state_nx  = T1;
					remain_nx = remain - 2'd1;
					mcycle_nx = (remain == 2'd1) ? 2'd0 : mcycle + 2'd1;
				end
			end
			T4: begin
				// decode of the new opcode is valid here
				state_nx  = (i_class == CL_HLT) ? TT : T1;
				remain_nx = i_extra_cycles;
				mcycle_nx = (i_extra_cycles != 2'd0) ? 2'd1 : 2'd0;
			end
			TT: state_nx = TT; // only reset leaves halt
			default: state_nx = TR;
		endcase
	end

	// status for the cycle about to start
	always_comb begin
		if (state_nx == TT)
			code_nx = CYCLE_BIH;
		else if (mcycle_nx == 2'd0)
			code_nx = CYCLE_OF;
		else if (mcycle_nx == 2'd2 && i_device_cycle)
			code_nx = (i_class == CL_OUT) ? CYCLE_DW : CYCLE_DR;
		else
			code_nx = CYCLE_MR;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state  <= TR;
			mcycle <= 2'd0;
			remain <= 2'd0;
			code   <= CYCLE_BIH; // idle levels on the pins
		end else begin
			state  <= state_nx;
			mcycle <= mcycle_nx;
			remain <= remain_nx;
			if (state_nx == T1 || state_nx == TT)
				code <= code_nx;
		end
	end

	assign o_state  = state;
	assign o_mcycle = mcycle;

	// ----------------------------------------
	// pins
	// ----------------------------------------

	assign bus_active = (state == T2) || (state == TW) || (state == T3);

	assign o_ale    = (state == T1);
	assign o_rd_n   = bus_active ? code[CTRL_RD] : 1'b1;
	assign o_wr_n   = bus_active ? code[CTRL_WR] : 1'b1;
	assign o_io_m_n = code[STAT_IOM];
	assign o_s1     = code[STAT_S1];
	assign o_s0     = code[STAT_S0];

	// ----------------------------------------
	// write strobes, each acts on the edge ending its state
	// ----------------------------------------

	assign last_mc = (mcycle != 2'd0) && (remain == 2'd1);

	assign o_ir_we   = (state == T3) && (mcycle == 2'd0);
	assign o_pc_inc  = (state == T3) && ((mcycle == 2'd0) || (code == CYCLE_MR));
	assign o_temp_we = (state == T3) && (mcycle == 2'd1) && i_device_cycle; // port number

	always_comb begin
		o_reg_we = 1'b0;
		case (i_class)
			CL_MOV, CL_ALU_R:
				o_reg_we = (state == T4);
			CL_MVI, CL_ALU_I, CL_IN:
				o_reg_we = (state == T3) && last_mc;
			default:
				o_reg_we = 1'b0;
		endcase
	end

endmodule

/* datapath/register_bank.sv */
`timescale 1ns/1ns

module register_bank (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_ir_we,
	input  logic                    i_temp_we,
	input  logic                    i_reg_we,
	input  logic                    i_pc_inc,
	input  cpu85_pkg::instr_class_e i_class,
	input  cpu85_pkg::reg_sel_t     i_dst,
	input  cpu85_pkg::reg_sel_t     i_src,
	input  cpu85_pkg::byte_t        i_rd_data,
	input  cpu85_pkg::byte_t        i_alu_res,
	output cpu85_pkg::byte_t        o_ir,
	output cpu85_pkg::byte_t        o_acc,
	output cpu85_pkg::byte_t        o_src_val,
	output cpu85_pkg::byte_t        o_temp,
	output cpu85_pkg::addr_t        o_pc
);
	import cpu85_pkg::*;

	// b c d e h l - a, slot 6 is the M operand and stays unwritten
	byte_t gpr [0:7];
	byte_t ir;
	byte_t temp;
	addr_t pc;
	byte_t wr_data;

	// immediate alu operand comes straight off the bus
	assign o_src_val = (i_class == CL_ALU_I) ? i_rd_data : gpr[i_src];

	always_comb begin
		case (i_class)
			CL_MOV:           wr_data = gpr[i_src];
			CL_ALU_R, CL_ALU_I: wr_data = i_alu_res;
			default:          wr_data = i_rd_data; // mvi, in
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reg_we)
			gpr[i_dst] <= wr_data;
		if (i_temp_we)
			temp <= i_rd_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= RESET_PC;
			ir <= OPC_NOP;
		end else begin
			if (i_ir_we)
				ir <= i_rd_data;
			if (i_pc_inc)
				pc <= pc + 16'd1;
		end
	end

	assign o_ir   = ir;
	assign o_acc  = gpr[REG_A];
	assign o_temp = temp;
	assign o_pc   = pc;

endmodule

/* datapath/alu8.sv */
`timescale 1ns/1ns

module alu8 (
	input  cpu85_pkg::alu_op_e i_op,
	input  cpu85_pkg::byte_t   i_a,
	input  cpu85_pkg::byte_t   i_b,
	output cpu85_pkg::byte_t   o_res
);
	import cpu85_pkg::*;

	// results wrap at 8 bits, carry is dropped
	always_comb begin
		case (i_op)
			ALU_ADD: o_res = i_a + i_b;
			ALU_SUB: o_res = i_a - i_b;
			ALU_ANA: o_res = i_a & i_b;
			ALU_XRA: o_res = i_a ^ i_b;
			ALU_ORA: o_res = i_a | i_b;
			default: o_res = i_a;
		endcase
	end

endmodule

/* src/bus_interface.sv */
`timescale 1ns/1ns

module bus_interface (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu85_pkg::tstate_e      i_state,
	input  cpu85_pkg::instr_class_e i_class,
	input  logic [1:0]              i_mcycle,
	input  cpu85_pkg::addr_t        i_pc,
	input  cpu85_pkg::byte_t        i_temp,
	input  cpu85_pkg::byte_t        i_acc,
	input  cpu85_pkg::byte_t        i_ad_in,
	output cpu85_pkg::byte_t        o_addr_hi,
	output cpu85_pkg::byte_t        o_ad_out,
	output logic                    o_ad_oe,
	output cpu85_pkg::byte_t        o_rd_data
);
	import cpu85_pkg::*;

	logic  dev_cycle;
	logic  data_phase;
	logic  wr_phase;
	addr_t addr;
	byte_t rd_q;

	// third machine cycle of in/out talks to the port
	assign dev_cycle  = (i_mcycle == 2'd2) && ((i_class == CL_IN) || (i_class == CL_OUT));
	assign data_phase = (i_state == T2) || (i_state == TW) || (i_state == T3);
	assign wr_phase   = dev_cycle && (i_class == CL_OUT) && data_phase;

	assign addr = dev_cycle ? {i_temp, i_temp} : i_pc; // port number on both halves

	assign o_addr_hi = addr[15:8];
	assign o_ad_out  = wr_phase ? i_acc : addr[7:0];
	assign o_ad_oe   = (i_state == T1) || wr_phase;

	// read byte is live during T3 and held after it
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rd_q <= 8'h00;
		else if (i_state == T3)
			rd_q <= i_ad_in;
	end

	assign o_rd_data = (i_state == T3) ? i_ad_in : rd_q;

endmodule

/* src/cpu85_top.sv */
`timescale 1ns/1ns

module cpu85_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             i_ready,
	input  cpu85_pkg::byte_t i_ad_in,
	output cpu85_pkg::byte_t o_addr_hi,
	output cpu85_pkg::byte_t o_ad_out,
	output logic             o_ad_oe,
	output logic             o_ale,
	output logic             o_rd_n,
	output logic             o_wr_n,
	output logic             o_io_m_n,
	output logic             o_s1,
	output logic             o_s0
);
	import cpu85_pkg::*;

	// decode
	instr_class_e cls;
	logic [1:0]   extra_cycles;
	logic         device_cycle;
	alu_op_e      alu_op;
	reg_sel_t     dst;
	reg_sel_t     src;

	// sequencing
	tstate_e    state;
	logic [1:0] mcycle;
	logic       ir_we;
	logic       temp_we;
	logic       reg_we;
	logic       pc_inc;

	// datapath
	byte_t ir;
	byte_t acc;
	byte_t src_val;
	byte_t temp;
	addr_t pc;
	byte_t alu_res;
	byte_t rd_data;

	instr_decoder u_decoder (
		.i_ir           (ir),
		.o_class        (cls),
		.o_extra_cycles (extra_cycles),
		.o_device_cycle (device_cycle),
		.o_alu_op       (alu_op),
		.o_dst          (dst),
		.o_src          (src)
	);

	cycle_sequencer u_sequencer (
		.clk            (clk),
		.rst            (rst),
		.i_ready        (i_ready),
		.i_class        (cls),
		.i_extra_cycles (extra_cycles),
		.i_device_cycle (device_cycle),
		.o_state        (state),
		.o_mcycle       (mcycle),
		.o_ale          (o_ale),
		.o_rd_n         (o_rd_n),
		.o_wr_n         (o_wr_n),
		.o_io_m_n       (o_io_m_n),
		.o_s1           (o_s1),
		.o_s0           (o_s0),
		.o_ir_we        (ir_we),
		.o_temp_we      (temp_we),
		.o_reg_we       (reg_we),
		.o_pc_inc       (pc_inc)
	);

	register_bank u_regs (
		.clk       (clk),
		.rst       (rst),
		.i_ir_we   (ir_we),
		.i_temp_we (temp_we),
		.i_reg_we  (reg_we),
		.i_pc_inc  (pc_inc),
		.i_class   (cls),
		.i_dst     (dst),
		.i_src     (src),
		.i_rd_data (rd_data),
		.i_alu_res (alu_res),
		.o_ir      (ir),
		.o_acc     (acc),
		.o_src_val (src_val),
		.o_temp    (temp),
		.o_pc      (pc)
	);

	alu8 u_alu (
		.i_op  (alu_op),
		.i_a   (acc),
		.i_b   (src_val),
		.o_res (alu_res)
	);

	bus_interface u_bus (
		.clk       (clk),
		.rst       (rst),
		.i_state   (state),
		.i_class   (cls),
		.i_mcycle  (mcycle),
		.i_pc      (pc),
		.i_temp    (temp),
		.i_acc     (acc),
		.i_ad_in   (i_ad_in),
		.o_addr_hi (o_addr_hi),
		.o_ad_out  (o_ad_out),
		.o_ad_oe   (o_ad_oe),
		.o_rd_data (rd_data)
	);

endmodule

/* tb/tb_cpu85.sv */
`timescale 1ns/1ns

module tb_cpu85;
	import cpu85_pkg::*;

	localparam int ALE_LIMIT  = 40;  // idle cycles that count as halted
	localparam int BUS_LIMIT  = 200; // bus cycles per test
	localparam int STRB_LIMIT = 8;   // cycles of RD_/WR_ after READY

	logic  clk;
	logic  rst;
	logic  i_ready;
	byte_t i_ad_in;
	byte_t o_addr_hi;
	byte_t o_ad_out;
	logic  o_ad_oe;
	logic  o_ale;
	logic  o_rd_n;
	logic  o_wr_n;
	logic  o_io_m_n;
	logic  o_s1;
	logic  o_s0;

	// memory and port model
	byte_t  mem [0:255];
	byte_t  port_in [0:255];
	byte_t  exp_port [$];
	byte_t  exp_data [$];
	logic   expect_halt;
	integer seed;
	int     n_tests;

	// bus history of the running test
	addr_t next_mem;
	int    mr_left; // operand bytes still due before the next fetch
	byte_t last_mem_byte;

	cpu85_top UUT (
		.clk       (clk),
		.rst       (rst),
		.i_ready   (i_ready),
		.i_ad_in   (i_ad_in),
		.o_addr_hi (o_addr_hi),
		.o_ad_out  (o_ad_out),
		.o_ad_oe   (o_ad_oe),
		.o_ale     (o_ale),
		.o_rd_n    (o_rd_n),
		.o_wr_n    (o_wr_n),
		.o_io_m_n  (o_io_m_n),
		.o_s1      (o_s1),
		.o_s0      (o_s0)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t got);
		if (got !== exp)
			abort_run($sformatf("Error %s expected %h got %h", name, exp, got));
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t got);
		if (got !== exp)
			abort_run($sformatf("Error %s expected %h got %h", name, exp, got));
	endtask

	task automatic check_code(input string name, input cycle_code_t exp, input cycle_code_t got);
		if (got !== exp)
			abort_run($sformatf("Error %s expected %h got %h", name, exp, got));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
			abort_run($sformatf("Error %s expected %h got %h", name, exp, got));
	endtask

	// status and strobes as seen on the pins, inta_ is not a pin
	function automatic cycle_code_t pin_code();
		return {1'b1, o_wr_n, o_rd_n, o_io_m_n, o_s1, o_s0};
	endfunction

	function automatic logic strobe_n(input logic is_write);
		return is_write ? o_wr_n : o_rd_n;
	endfunction

	// immediate or port byte that follows a kept opcode
	function automatic int operand_bytes(input byte_t op);
		if (op == 8'hDB || op == 8'hD3)
			return 1;
		if (op[2:0] != 3'b110)
			return 0;
		if (op[7:6] == 2'b00)
			return (op[5:3] != 3'b110) ? 1 : 0; // mvi r
		if (op[7:6] == 2'b11) begin
			case (op[5:3])
				3'd0, 3'd2, 3'd4, 3'd5, 3'd6: return 1; // adi sui ani xri ori
				default: return 0;
			endcase
		end
		return 0;
	endfunction

	task automatic check_idle_pins(input string when);
		check_bit({when, " o_ale"}, 1'b0, o_ale);
		check_bit({when, " o_ad_oe"}, 1'b0, o_ad_oe);
		check_code({when, " status"}, CYCLE_BIH, pin_code());
	endtask

	// ----------------------------------------
	// bus model
	// ----------------------------------------

	task automatic reset_dut();
		@(posedge clk);
		rst     <= 1'b1;
		i_ready <= 1'b1;
		i_ad_in <= 8'h00;
		repeat (8) begin
			@(negedge clk);
			check_idle_pins("reset");
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_idle_pins("TR"); // one cycle in TR before the first T1
	endtask

	task automatic wait_ale(output bit seen);
		int cnt;

		cnt  = 0;
		seen = o_ale;
		while (!seen && cnt < ALE_LIMIT) begin
			@(negedge clk);
			cnt++;
			seen = o_ale;
		end
	endtask

	// entered at the falling edge inside T1
	task automatic run_bus_cycle();
		addr_t       addr;
		cycle_code_t code;
		byte_t       rd_val;
		byte_t       wr_val;
		int          waits;
		int          low_cnt;
		logic        is_write;

		addr   = {o_addr_hi, o_ad_out};
		wr_val = 8'h00;
		check_bit("o_ad_oe in T1", 1'b1, o_ad_oe);
		rd_val = o_io_m_n ? port_in[addr[7:0]] : mem[addr[7:0]];
		waits  = $random(seed) & 3;
		@(posedge clk);
		i_ad_in <= rd_val;
		i_ready <= (waits == 0);
		@(negedge clk); // T2
		code     = pin_code();
		is_write = !o_wr_n;
		check_bit("o_ale in T2", 1'b0, o_ale);
		if (o_wr_n && o_rd_n)
			abort_run("neither RD_ nor WR_ went low in T2");
		for (int i = 1; i <= waits; i++) begin
			@(posedge clk);
			if (i == waits)
				i_ready <= 1'b1;
			@(negedge clk);
			if (strobe_n(is_write) !== 1'b0)
				abort_run("RD_ or WR_ rose during a wait state");
		end
		low_cnt = 0;
		@(negedge clk);
		while (strobe_n(is_write) === 1'b0 && low_cnt < STRB_LIMIT) begin
			if (is_write) begin
				check_bit("o_ad_oe in write", 1'b1, o_ad_oe);
				wr_val = o_ad_out; // last sample is T3
			end else begin
				check_bit("o_ad_oe in read", 1'b0, o_ad_oe);
			end
			low_cnt++;
			@(negedge clk);
		end
		if (low_cnt >= STRB_LIMIT)
			abort_run("timeout: RD_ or WR_ never returned high after READY");
		if (low_cnt != 1)
			abort_run("T3 did not follow READY by exactly one cycle");

		if (is_write) begin
			if (exp_port.size() == 0)
				abort_run("device write with no expected write left");
			check_code("write cycle status", CYCLE_DW, code);
			check_addr("device write address", {exp_port[0], exp_port[0]}, addr);
			check_byte("o_ad_out write data", exp_data[0], wr_val);
			void'(exp_port.pop_front());
			void'(exp_data.pop_front());
		end else if (code[STAT_IOM]) begin
			check_code("device read status", CYCLE_DR, code);
			check_addr("device read address", {last_mem_byte, last_mem_byte}, addr);
		end else begin
			check_code("memory cycle status", (mr_left > 0) ? CYCLE_MR : CYCLE_OF, code);
			check_addr("memory address", next_mem, addr);
			if (mr_left > 0)
				mr_left--;
			else
				mr_left = operand_bytes(rd_val);
			next_mem      = next_mem + 16'd1;
			last_mem_byte = rd_val;
		end
	endtask

	task automatic check_halt();
		for (int i = 0; i < ALE_LIMIT; i++) begin
			check_code("halt status", CYCLE_BIH, pin_code());
			check_bit("o_ad_oe in halt", 1'b0, o_ad_oe);
			check_bit("o_ale in halt", 1'b0, o_ale);
			@(negedge clk);
		end
	endtask

	task automatic clear_test();
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]]     = 8'h00;
			port_in[i[7:0]] = 8'h00;
		end
		exp_port.delete();
		exp_data.delete();
		expect_halt = 1'b0;
	endtask

	task automatic run_test();
		bit seen;
		int cycles;

		n_tests++;
		reset_dut();
		next_mem = 16'h0000;
		mr_left  = 0;
		cycles   = 0;
		seen     = 1'b1;
		while (seen && cycles < BUS_LIMIT && (expect_halt || exp_port.size() != 0)) begin
			wait_ale(seen);
			if (seen) begin
				run_bus_cycle();
				cycles++;
			end
		end
		if (exp_port.size() != 0)
			abort_run("timeout: an expected device write never came");
		if (expect_halt) begin
			if (seen)
				abort_run("timeout: HLT did not stop the bus within the cycle limit");
			else
				check_halt();
		end
	endtask

	// ----------------------------------------
	// test file
	// ----------------------------------------

	initial begin
		integer          fd;
		integer          n;
		byte_t           kind;
		addr_t           a;
		byte_t           v;
		bit              pending;
		logic [8*80-1:0] rest;

		rst     = 1'b1;
		i_ready = 1'b1;
		i_ad_in = 8'h00;
		seed    = 15;
		n_tests = 0;
		pending = 1'b0;
		clear_test();
		fd = $fopen("tb/cpu85_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open tb/cpu85_tests.txt");
		n = $fscanf(fd, " %c", kind);
		while (n == 1) begin
			case (kind)
				"T": begin
					if (pending)
						run_test();
					clear_test();
					pending = 1'b1;
				end
				"M", "P", "W": begin
					n = $fscanf(fd, " %h %h", a, v);
					if (n != 2 || a > 16'h00ff)
						abort_run("bad M, P or W line in the test file");
					if (kind == "M")
						mem[a[7:0]] = v;
					else if (kind == "P")
						port_in[a[7:0]] = v;
					else begin
						exp_port.push_back(a[7:0]);
						exp_data.push_back(v);
					end
				end
				"H": expect_halt = 1'b1;
				"#": n = $fgets(rest, fd); // comment line
				default: abort_run("unknown line kind in the test file");
			endcase
			n = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
		if (pending)
			run_test();
		if (n_tests == 0)
			abort_run("the test file holds no tests");
		$display("Done: no errors");
		$finish;
	end

endmodule

/* tb/cpu85_tests.txt */
# T new test, M addr byte program memory, P port byte value an IN returns
# W port byte next expected OUT, H halt expected; all values hex
# mvi a then out
T
M 0000 3E
M 0001 5A
M 0002 D3
M 0003 10
M 0004 76
W 10 5A
H
# mvi b, mov a b, mvi c, add c, sui, out
T
M 0000 06
M 0001 37
M 0002 78
M 0003 0E
M 0004 25
M 0005 81
M 0006 D6
M 0007 70
M 0008 D3
M 0009 20
M 000A 76
W 20 EC
H
# in, mov d a, mvi a, sub d with wrap, out twice
T
M 0000 DB
M 0001 40
M 0002 57
M 0003 3E
M 0004 10
M 0005 92
M 0006 D3
M 0007 41
M 0008 7A
M 0009 D3
M 000A 42
M 000B 76
P 40 C3
W 41 4D
W 42 C3
H
# ana e, xri, dropped opcode as nop, ora l, out
T
M 0000 3E
M 0001 F0
M 0002 1E
M 0003 3C
M 0004 A3
M 0005 EE
M 0006 3C
M 0007 07
M 0008 2E
M 0009 A1
M 000A B5
M 000B D3
M 000C 50
M 000D 76
W 50 AD
H

/* cpu85.f */
common/cpu85_pkg.sv
control/instr_decoder.sv
control/cycle_sequencer.sv
datapath/register_bank.sv
datapath/alu8.sv
src/bus_interface.sv
src/cpu85_top.sv
tb/tb_cpu85.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_cpu85 -f cpu85.f -o tb_cpu85
status=0
./obj_dir/tb_cpu85 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Done: errors found" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
